// File: rtl/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// core widths
`define CPU_XLEN      32
`define CPU_REG_AW    5
`define CPU_REG_NUM   32

// MIPS reset exception entry
`define CPU_RESET_PC  32'hBFC0_0000

`endif

// File: rtl/cpu_isa_pkg.sv
`include "cpu_defs.svh"

package cpu_isa_pkg;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,             // R-type, decoded by funct
        OP_J       = 6'h02,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } funct_e;

    typedef struct packed {
        opcode_e                  opcode;
        logic [`CPU_REG_AW-1:0]   rs;
        logic [`CPU_REG_AW-1:0]   rt;
        logic [`CPU_REG_AW-1:0]   rd;
        logic [4:0]               shamt;
        funct_e                   funct;
    } r_fmt_t;

    typedef struct packed {
        opcode_e                  opcode;
        logic [`CPU_REG_AW-1:0]   rs;
        logic [`CPU_REG_AW-1:0]   rt;
        logic [15:0]              imm;
    } i_fmt_t;

    typedef struct packed {
        opcode_e                  opcode;
        logic [25:0]              index;    // word index inside the 256MB region
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        j_fmt_t j;
    } instr_u;

    // a cleared control bundle decodes as ALU_ADD
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE
    } branch_e;

endpackage

// File: rtl/cpu_pipe_pkg.sv
`include "cpu_defs.svh"

package cpu_pipe_pkg;

    typedef struct packed {
        cpu_isa_pkg::alu_op_e alu_op;
        logic                 imm_sel;      // operand b from the immediate
        logic                 reg_write;
        logic                 mem_read;
        logic                 mem_write;
        logic                 mem_to_reg;   // writeback takes load data
        cpu_isa_pkg::branch_e branch;
    } ctrl_t;

    typedef struct packed {
        logic                  valid;
        logic [`CPU_XLEN-1:0]  pc4;
        logic [`CPU_XLEN-1:0]  instr;
    } if_id_t;

    typedef struct packed {
        ctrl_t                   ctrl;
        logic [`CPU_XLEN-1:0]    pc4;
        logic [`CPU_XLEN-1:0]    op_a;
        logic [`CPU_XLEN-1:0]    op_b;
        logic [`CPU_XLEN-1:0]    imm;
        logic [`CPU_REG_AW-1:0]  rs;        // zero when not a source
        logic [`CPU_REG_AW-1:0]  rt;        // zero when not a source
        logic [`CPU_REG_AW-1:0]  dst;
    } id_ex_t;

    typedef struct packed {
        ctrl_t                   ctrl;
        logic [`CPU_XLEN-1:0]    pc;
        logic [`CPU_XLEN-1:0]    alu_res;
        logic [`CPU_XLEN-1:0]    store_data;
        logic [`CPU_REG_AW-1:0]  dst;
    } ex_mem_t;

    typedef struct packed {
        logic                    we;
        logic [`CPU_REG_AW-1:0]  dst;
        logic [`CPU_XLEN-1:0]    data;
        logic [`CPU_XLEN-1:0]    pc;
    } wb_bus_t;

    // operand source in EXE
    typedef enum logic [1:0] {
        FWD_REG,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

endpackage

// File: rtl/cpu_regfile.sv
`include "cpu_defs.svh"

module cpu_regfile (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  logic [`CPU_REG_AW-1:0]  rs_i,
    input  logic [`CPU_REG_AW-1:0]  rt_i,
    input  cpu_pipe_pkg::wb_bus_t   wb_i,
    output logic [`CPU_XLEN-1:0]    rs_data_o,
    output logic [`CPU_XLEN-1:0]    rt_data_o
);
    logic [`CPU_XLEN-1:0] rf_q [`CPU_REG_NUM];

    // write in WB is visible to the read in ID of the same cycle
    function automatic logic [`CPU_XLEN-1:0] read_port(input logic [`CPU_REG_AW-1:0] idx);
        return (wb_i.we && wb_i.dst == idx) ? wb_i.data : rf_q[idx];
    endfunction

    always_comb begin
        rs_data_o = read_port(rs_i);
        rt_data_o = read_port(rt_i);
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rf_q <= '{default: '0};
        end else if (wb_i.we) begin
            rf_q[wb_i.dst] <= wb_i.data;    // decode never targets r0
        end
    end

    a_r0_zero: assert property (@(posedge clk) disable iff (!arst_n_i) rf_q[0] == '0)
        else $error("register zero was written");

endmodule

// File: rtl/cpu_fetch.sv
`include "cpu_defs.svh"

module cpu_fetch (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  stall_i,
    input  logic                  branch_taken_i,
    input  logic [`CPU_XLEN-1:0]  branch_target_i,
    input  logic                  jump_taken_i,
    input  logic [`CPU_XLEN-1:0]  jump_target_i,
    input  logic [`CPU_XLEN-1:0]  inst_sram_rdata_i,
    output logic                  inst_sram_en_o,
    output logic [`CPU_XLEN-1:0]  inst_sram_addr_o,
    output cpu_pipe_pkg::if_id_t  if_id_o
);
    import cpu_pipe_pkg::*;

    logic [`CPU_XLEN-1:0] pc_q;         // address of the word coming back now
    logic [`CPU_XLEN-1:0] pc4;
    logic [`CPU_XLEN-1:0] hold_q;
    logic [`CPU_XLEN-1:0] instr;
    logic                 run_q;
    logic                 fetch_q;      // a word returns this cycle
    logic                 hold_vld_q;
    if_id_t               if_id_q;

    assign pc4            = pc_q + 32'd4;
    assign inst_sram_en_o = run_q && !stall_i;
    assign instr          = hold_vld_q ? hold_q : inst_sram_rdata_i;

    always_comb begin
        if (branch_taken_i) begin
            inst_sram_addr_o = branch_target_i;
        end else if (jump_taken_i) begin
            inst_sram_addr_o = jump_target_i;
        end else begin
            inst_sram_addr_o = pc4;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            run_q      <= 1'b0;
            fetch_q    <= 1'b0;
            hold_vld_q <= 1'b0;
            pc_q       <= `CPU_RESET_PC - 32'd4;   // first pc4 is the reset vector
            if_id_q    <= '0;
        end else begin
            run_q      <= 1'b1;
            hold_vld_q <= stall_i;
            if (inst_sram_en_o) begin
                pc_q <= inst_sram_addr_o;
            end
            if (!stall_i) begin
                fetch_q       <= inst_sram_en_o;
                if_id_q.valid <= fetch_q && !branch_taken_i; // kill the word past the slot
                if_id_q.pc4   <= pc4;
                if_id_q.instr <= instr;
            end
        end
    end

    // SRAM output is not kept while the enable is low
    always_ff @(posedge clk) begin
        if (stall_i) begin
            hold_q <= instr;
        end
    end

    assign if_id_o = if_id_q;

endmodule

// File: rtl/cpu_decode.sv
`include "cpu_defs.svh"

module cpu_decode (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  cpu_pipe_pkg::if_id_t    if_id_i,
    input  logic                    stall_i,
    input  cpu_pipe_pkg::wb_bus_t   wb_i,
    output cpu_pipe_pkg::id_ex_t    id_ex_o,
    output logic [`CPU_REG_AW-1:0]  id_rs_o,
    output logic [`CPU_REG_AW-1:0]  id_rt_o,
    output logic                    id_uses_rt_o,
    output logic                    jump_taken_o,
    output logic [`CPU_XLEN-1:0]    jump_target_o
);
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    instr_u                  ins;
    ctrl_t                   ctrl;
    logic                    illegal;
    logic                    uses_rs;
    logic                    uses_rt;
    logic                    sign_ext;
    logic [`CPU_REG_AW-1:0]  dst;
    logic [`CPU_XLEN-1:0]    rs_data;
    logic [`CPU_XLEN-1:0]    rt_data;
    id_ex_t                  id_ex_d;
    id_ex_t                  id_ex_q;

    assign ins = if_id_i.instr;

    cpu_regfile u_regfile (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .rs_i      (ins.r.rs),
        .rt_i      (ins.r.rt),
        .wb_i      (wb_i),
        .rs_data_o (rs_data),
        .rt_data_o (rt_data)
    );

    always_comb begin
        ctrl     = '0;
        illegal  = 1'b0;
        uses_rs  = 1'b1;
        uses_rt  = 1'b0;
        sign_ext = 1'b1;
        dst      = ins.i.rt;
        case (ins.r.opcode)
            OP_SPECIAL: begin
                ctrl.reg_write = 1'b1;
                uses_rt        = 1'b1;
                dst            = ins.r.rd;
                case (ins.r.funct)
                    FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    default: illegal     = 1'b1;
                endcase
            end
            OP_ADDIU: begin
                ctrl.imm_sel   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            OP_ORI: begin
                ctrl.imm_sel   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = ALU_OR;
                sign_ext       = 1'b0;      // logical immediate
            end
            OP_LUI: begin
                ctrl.imm_sel   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = ALU_LUI;
                uses_rs        = 1'b0;
            end
            OP_LW: begin
                ctrl.imm_sel    = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            OP_SW: begin
                ctrl.imm_sel   = 1'b1;
                ctrl.mem_write = 1'b1;
                uses_rt        = 1'b1;      // store data
            end
            OP_BEQ: begin
                ctrl.branch = BR_EQ;
                uses_rt     = 1'b1;
            end
            OP_BNE: begin
                ctrl.branch = BR_NE;
                uses_rt     = 1'b1;
            end
            OP_J:    uses_rs = 1'b0;
            default: illegal = 1'b1;
        endcase
        // r0 is never a writeback target
        ctrl.reg_write = ctrl.reg_write && (dst != '0);
    end

    always_comb begin
        id_ex_d.ctrl = ctrl;
        id_ex_d.pc4  = if_id_i.pc4;
        id_ex_d.op_a = rs_data;
        id_ex_d.op_b = rt_data;
        id_ex_d.imm  = {{16{sign_ext && ins.i.imm[15]}}, ins.i.imm};
        id_ex_d.rs   = uses_rs ? ins.r.rs : '0;
        id_ex_d.rt   = uses_rt ? ins.r.rt : '0;
        id_ex_d.dst  = dst;
        // an empty slot neither writes nor reads
        if (!if_id_i.valid || illegal) begin
            id_ex_d.ctrl = '0;
            id_ex_d.rs   = '0;
            id_ex_d.rt   = '0;
        end
    end

    assign id_rs_o       = uses_rs ? ins.r.rs : '0;
    assign id_rt_o       = ins.r.rt;
    assign id_uses_rt_o  = uses_rt;
    assign jump_taken_o  = if_id_i.valid && (ins.j.opcode == OP_J);
    assign jump_target_o = {if_id_i.pc4[31:28], ins.j.index, 2'b00};

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_ex_q <= '0;
        end else if (stall_i) begin
            id_ex_q <= '0;                  // load-use bubble
        end else begin
            id_ex_q <= id_ex_d;
        end
    end

    assign id_ex_o = id_ex_q;

    // anything the fetch lets through must be a known instruction
    a_no_illegal: assert property (@(posedge clk) disable iff (!arst_n_i)
        (if_id_i.valid && !stall_i) |-> !illegal)
        else $error("unknown opcode entering EXE");

endmodule

// File: rtl/cpu_hazard.sv
`include "cpu_defs.svh"

module cpu_hazard (
    input  logic [`CPU_REG_AW-1:0]  id_rs_i,
    input  logic [`CPU_REG_AW-1:0]  id_rt_i,
    input  logic                    id_uses_rt_i,
    input  cpu_pipe_pkg::id_ex_t    id_ex_i,
    input  cpu_pipe_pkg::ex_mem_t   ex_mem_i,
    input  cpu_pipe_pkg::wb_bus_t   wb_i,
    output logic                    stall_o,
    output cpu_pipe_pkg::fwd_sel_e  fwd_a_o,
    output cpu_pipe_pkg::fwd_sel_e  fwd_b_o
);
    import cpu_pipe_pkg::*;

    logic ex_load;

    // youngest producer wins
    // a source index of 0 never matches a writer
    function automatic fwd_sel_e pick_src(input logic [`CPU_REG_AW-1:0] src);
        if (ex_mem_i.ctrl.reg_write && ex_mem_i.dst == src) begin
            return FWD_MEM;
        end
        if (wb_i.we && wb_i.dst == src) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    assign ex_load = id_ex_i.ctrl.mem_read && id_ex_i.ctrl.reg_write;

    // a reader right behind a load waits one cycle for the WB data
    assign stall_o = ex_load &&
                     ((id_ex_i.dst == id_rs_i) || (id_uses_rt_i && id_ex_i.dst == id_rt_i));

    always_comb begin
        fwd_a_o = pick_src(id_ex_i.rs);
        fwd_b_o = pick_src(id_ex_i.rt);
    end

endmodule

// File: rtl/cpu_execute.sv
`include "cpu_defs.svh"

module cpu_execute (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  cpu_pipe_pkg::id_ex_t    id_ex_i,
    input  cpu_pipe_pkg::fwd_sel_e  fwd_a_i,
    input  cpu_pipe_pkg::fwd_sel_e  fwd_b_i,
    input  cpu_pipe_pkg::wb_bus_t   wb_i,
    output cpu_pipe_pkg::ex_mem_t   ex_mem_o,
    output logic                    branch_taken_o,
    output logic [`CPU_XLEN-1:0]    branch_target_o
);
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    logic [`CPU_XLEN-1:0] opnd_a;
    logic [`CPU_XLEN-1:0] opnd_b;      // also the store data
    logic [`CPU_XLEN-1:0] alu_b;
    logic [`CPU_XLEN-1:0] alu_res;
    ex_mem_t              ex_mem_q;

    function automatic logic [`CPU_XLEN-1:0] fwd_mux(input fwd_sel_e sel,
                                                     input logic [`CPU_XLEN-1:0] reg_val);
        case (sel)
            FWD_MEM: return ex_mem_q.alu_res;
            FWD_WB:  return wb_i.data;
            default: return reg_val;
        endcase
    endfunction

    always_comb begin
        opnd_a = fwd_mux(fwd_a_i, id_ex_i.op_a);
        opnd_b = fwd_mux(fwd_b_i, id_ex_i.op_b);
    end

    assign alu_b = id_ex_i.ctrl.imm_sel ? id_ex_i.imm : opnd_b;

    always_comb begin
        case (id_ex_i.ctrl.alu_op)
            ALU_SUB: alu_res = opnd_a - alu_b;
            ALU_AND: alu_res = opnd_a & alu_b;
            ALU_OR:  alu_res = opnd_a | alu_b;
            ALU_SLT: alu_res = {31'b0, $signed(opnd_a) < $signed(alu_b)};
            ALU_LUI: alu_res = {alu_b[15:0], 16'b0};
            default: alu_res = opnd_a + alu_b;
        endcase
    end

    // compare uses the forwarded registers, never the immediate
    always_comb begin
        case (id_ex_i.ctrl.branch)
            BR_EQ:   branch_taken_o = (opnd_a == opnd_b);
            BR_NE:   branch_taken_o = (opnd_a != opnd_b);
            default: branch_taken_o = 1'b0;
        endcase
    end

    assign branch_target_o = id_ex_i.pc4 + {id_ex_i.imm[`CPU_XLEN-3:0], 2'b00};

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_mem_q <= '0;
        end else begin
            ex_mem_q.ctrl       <= id_ex_i.ctrl;
            ex_mem_q.pc         <= id_ex_i.pc4 - 32'd4;
            ex_mem_q.alu_res    <= alu_res;
            ex_mem_q.store_data <= opnd_b;
            ex_mem_q.dst        <= id_ex_i.dst;
        end
    end

    assign ex_mem_o = ex_mem_q;

    // the load-use stall must keep a load in MEM away from the EXE operands
    a_no_mem_load_fwd: assert property (@(posedge clk) disable iff (!arst_n_i)
        (fwd_a_i == FWD_MEM || fwd_b_i == FWD_MEM) |-> !ex_mem_q.ctrl.mem_read)
        else $error("forward from a load still in MEM");

endmodule

// File: rtl/cpu_memwb.sv
`include "cpu_defs.svh"

module cpu_memwb (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  cpu_pipe_pkg::ex_mem_t  ex_mem_i,
    input  logic [`CPU_XLEN-1:0]   data_sram_rdata_i,
    output logic                   data_sram_en_o,
    output logic                   data_sram_we_o,
    output logic [`CPU_XLEN-1:0]   data_sram_addr_o,
    output logic [`CPU_XLEN-1:0]   data_sram_wdata_o,
    output cpu_pipe_pkg::wb_bus_t  wb_o
);
    import cpu_pipe_pkg::*;

    wb_bus_t wb_q;
    logic    from_mem_q;

    // whole-word access issued straight from MEM
    assign data_sram_en_o    = ex_mem_i.ctrl.mem_read || ex_mem_i.ctrl.mem_write;
    assign data_sram_we_o    = ex_mem_i.ctrl.mem_write;
    assign data_sram_addr_o  = ex_mem_i.alu_res;
    assign data_sram_wdata_o = ex_mem_i.store_data;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_q       <= '0;
            from_mem_q <= 1'b0;
        end else begin
            wb_q.we    <= ex_mem_i.ctrl.reg_write;
            wb_q.dst   <= ex_mem_i.dst;
            wb_q.data  <= ex_mem_i.alu_res;
            wb_q.pc    <= ex_mem_i.pc;
            from_mem_q <= ex_mem_i.ctrl.mem_to_reg;
        end
    end

    // load data arrives during WB
    always_comb begin
        wb_o = wb_q;
        if (from_mem_q) begin
            wb_o.data = data_sram_rdata_i;
        end
    end

    a_rw_exclusive: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(ex_mem_i.ctrl.mem_read && ex_mem_i.ctrl.mem_write))
        else $error("data SRAM read and write in one cycle");

endmodule

// File: rtl/mycpu_top.sv
`include "cpu_defs.svh"

module mycpu_top (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  logic [`CPU_XLEN-1:0]    inst_sram_rdata_i,
    input  logic [`CPU_XLEN-1:0]    data_sram_rdata_i,
    output logic                    inst_sram_en_o,
    output logic [`CPU_XLEN-1:0]    inst_sram_addr_o,
    output logic                    data_sram_en_o,
    output logic                    data_sram_we_o,
    output logic [`CPU_XLEN-1:0]    data_sram_addr_o,
    output logic [`CPU_XLEN-1:0]    data_sram_wdata_o,
    output logic [`CPU_XLEN-1:0]    debug_wb_pc_o,
    output logic [3:0]              debug_wb_rf_wen_o,
    output logic [`CPU_REG_AW-1:0]  debug_wb_rf_wnum_o,
    output logic [`CPU_XLEN-1:0]    debug_wb_rf_wdata_o
);
    import cpu_pipe_pkg::*;

    if_id_t                  if_id;
    id_ex_t                  id_ex;
    ex_mem_t                 ex_mem;
    wb_bus_t                 wb;
    fwd_sel_e                fwd_a;
    fwd_sel_e                fwd_b;
    logic                    stall;
    logic                    branch_taken;
    logic [`CPU_XLEN-1:0]    branch_target;
    logic                    jump_taken;
    logic [`CPU_XLEN-1:0]    jump_target;
    logic [`CPU_REG_AW-1:0]  id_rs;
    logic [`CPU_REG_AW-1:0]  id_rt;
    logic                    id_uses_rt;

    cpu_fetch u_fetch (
        .clk               (clk),
        .arst_n_i          (arst_n_i),
        .stall_i           (stall),
        .branch_taken_i    (branch_taken),
        .branch_target_i   (branch_target),
        .jump_taken_i      (jump_taken),
        .jump_target_i     (jump_target),
        .inst_sram_rdata_i (inst_sram_rdata_i),
        .inst_sram_en_o    (inst_sram_en_o),
        .inst_sram_addr_o  (inst_sram_addr_o),
        .if_id_o           (if_id)
    );

    cpu_decode u_decode (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .if_id_i       (if_id),
        .stall_i       (stall),
        .wb_i          (wb),
        .id_ex_o       (id_ex),
        .id_rs_o       (id_rs),
        .id_rt_o       (id_rt),
        .id_uses_rt_o  (id_uses_rt),
        .jump_taken_o  (jump_taken),
        .jump_target_o (jump_target)
    );

    cpu_hazard u_hazard (
        .id_rs_i      (id_rs),
        .id_rt_i      (id_rt),
        .id_uses_rt_i (id_uses_rt),
        .id_ex_i      (id_ex),
        .ex_mem_i     (ex_mem),
        .wb_i         (wb),
        .stall_o      (stall),
        .fwd_a_o      (fwd_a),
        .fwd_b_o      (fwd_b)
    );

    cpu_execute u_execute (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .id_ex_i         (id_ex),
        .fwd_a_i         (fwd_a),
        .fwd_b_i         (fwd_b),
        .wb_i            (wb),
        .ex_mem_o        (ex_mem),
        .branch_taken_o  (branch_taken),
        .branch_target_o (branch_target)
    );

    cpu_memwb u_memwb (
        .clk               (clk),
        .arst_n_i          (arst_n_i),
        .ex_mem_i          (ex_mem),
        .data_sram_rdata_i (data_sram_rdata_i),
        .data_sram_en_o    (data_sram_en_o),
        .data_sram_we_o    (data_sram_we_o),
        .data_sram_addr_o  (data_sram_addr_o),
        .data_sram_wdata_o (data_sram_wdata_o),
        .wb_o              (wb)
    );

    // retirement trace
    assign debug_wb_pc_o       = wb.pc;
    assign debug_wb_rf_wen_o   = {4{wb.we}};       // every register write covers all byte lanes
    assign debug_wb_rf_wnum_o  = wb.dst;
    assign debug_wb_rf_wdata_o = wb.data;

endmodule

// File: tests/tb_mycpu.sv
`include "cpu_defs.svh"

module tb_mycpu;
    localparam int          CASE_WORDS = 1024;
    localparam int          MEM_WORDS  = 256;
    localparam int          DATA_BASE  = 'h100;     // data image
    localparam int          STORE_BASE = 'h200;     // address, data pairs
    localparam int          TRACE_BASE = 'h280;     // pc, register, value
    localparam logic [31:0] LIST_END   = 32'hffff_ffff;

    logic                   clk;
    logic                   arst_n;
    logic [`CPU_XLEN-1:0]   inst_sram_rdata;
    logic [`CPU_XLEN-1:0]   data_sram_rdata;
    logic                   inst_sram_en;
    logic [`CPU_XLEN-1:0]   inst_sram_addr;
    logic                   data_sram_en;
    logic                   data_sram_we;
    logic [`CPU_XLEN-1:0]   data_sram_addr;
    logic [`CPU_XLEN-1:0]   data_sram_wdata;
    logic [`CPU_XLEN-1:0]   debug_wb_pc;
    logic [3:0]             debug_wb_rf_wen;
    logic [`CPU_REG_AW-1:0] debug_wb_rf_wnum;
    logic [`CPU_XLEN-1:0]   debug_wb_rf_wdata;

    logic [31:0] case_mem [CASE_WORDS];
    logic [31:0] imem [MEM_WORDS];
    logic [31:0] dmem [MEM_WORDS];
    int          trace_ptr;                      // next expected retirement
    int          store_ptr;                      // next expected address and data pair
    int          trace_len;
    bit          retired;

    mycpu_top u_mycpu_top (
        .clk                 (clk),
        .arst_n_i            (arst_n),
        .inst_sram_rdata_i   (inst_sram_rdata),
        .data_sram_rdata_i   (data_sram_rdata),
        .inst_sram_en_o      (inst_sram_en),
        .inst_sram_addr_o    (inst_sram_addr),
        .data_sram_en_o      (data_sram_en),
        .data_sram_we_o      (data_sram_we),
        .data_sram_addr_o    (data_sram_addr),
        .data_sram_wdata_o   (data_sram_wdata),
        .debug_wb_pc_o       (debug_wb_pc),
        .debug_wb_rf_wen_o   (debug_wb_rf_wen),
        .debug_wb_rf_wnum_o  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata_o (debug_wb_rf_wdata)
    );

    always #4 clk = ~clk;

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("MISMATCH %s: got %h, expected %h at time %0t",
                                        name, got, exp, $time));
        end
    endtask

    task automatic load_cases();
        int k;
        for (k = 0; k < MEM_WORDS; k++) begin
            case_mem[k]             = {6'h00, k[4:0], 2'b00, k[7:5], 10'd0, 6'h21}; // addu to r0
            case_mem[DATA_BASE + k] = {8'hda, k[7:0], 8'h5a, ~k[7:0]};
        end
        for (k = STORE_BASE; k < CASE_WORDS; k++) begin
            case_mem[k] = LIST_END;
        end
        $readmemh("tests/cpu_cases.hex", case_mem);
        for (k = 0; k < MEM_WORDS; k++) begin
            imem[k] = case_mem[k];
            dmem[k] = case_mem[DATA_BASE + k];
        end
        trace_len = 0;
        while (case_mem[TRACE_BASE + 3 * trace_len] !== LIST_END) begin
            trace_len++;
        end
    endtask

    // both SRAMs answer one cycle after the request
    always @(posedge clk) begin
        if (inst_sram_en) begin
            inst_sram_rdata <= imem[inst_sram_addr[9:2]];
        end
    end

    always @(posedge clk) begin
        if (data_sram_en && data_sram_we) begin
            dmem[data_sram_addr[9:2]] <= data_sram_wdata;
        end else if (data_sram_en) begin
            data_sram_rdata <= dmem[data_sram_addr[9:2]];
        end
    end

    // outputs settle between edges
    always @(negedge clk) begin
        if (arst_n && debug_wb_rf_wen != 4'h0) begin
            if (case_mem[TRACE_BASE + 3 * trace_ptr] === LIST_END) begin
                stop_with_failure("register writeback after the end of the expected trace");
            end else begin
                check_value("debug_wb_rf_wen_o", {28'b0, debug_wb_rf_wen}, 32'h0000_000f);
                check_value("debug_wb_pc_o", debug_wb_pc, case_mem[TRACE_BASE + 3 * trace_ptr]);
                check_value("debug_wb_rf_wnum_o", {27'b0, debug_wb_rf_wnum},
                            case_mem[TRACE_BASE + 3 * trace_ptr + 1]);
                check_value("debug_wb_rf_wdata_o", debug_wb_rf_wdata,
                            case_mem[TRACE_BASE + 3 * trace_ptr + 2]);
                trace_ptr++;
                retired = 1'b1;
            end
        end
        if (arst_n && data_sram_en && !retired) begin
            stop_with_failure("data SRAM accessed before the first instruction retired");
        end else if (arst_n && data_sram_en && data_sram_we) begin
            if (case_mem[STORE_BASE + 2 * store_ptr] === LIST_END) begin
                stop_with_failure("store issued that is not in the expected list");
            end else begin
                check_value("data_sram_addr_o", data_sram_addr,
                            case_mem[STORE_BASE + 2 * store_ptr]);
                check_value("data_sram_wdata_o", data_sram_wdata,
                            case_mem[STORE_BASE + 2 * store_ptr + 1]);
                store_ptr++;
            end
        end
    end

    initial begin : watchdog
        wait (trace_len > 0);
        repeat (20 * trace_len + 100) @(posedge clk);
        stop_with_failure("timeout, the writeback trace did not complete in time");
    end

    initial begin : main
        clk             = 1'b0;
        arst_n          = 1'b0;
        inst_sram_rdata = '0;
        data_sram_rdata = '0;
        trace_ptr       = 0;
        store_ptr       = 0;
        retired         = 1'b0;
        load_cases();
        if (trace_len == 0) begin
            stop_with_failure("no writeback trace found in the cases file");
        end
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        while (!inst_sram_en) begin
            @(negedge clk);
        end
        check_value("inst_sram_addr_o", inst_sram_addr, `CPU_RESET_PC);
        while (trace_ptr < trace_len) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);             // nothing more may retire
        if (case_mem[STORE_BASE + 2 * store_ptr] !== LIST_END) begin
            stop_with_failure("an expected store was never issued");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

// File: tests/cpu_cases.hex
// @000 program words, @110 data image words, @200 expected stores as address then data,
// @280 expected writebacks as pc, register, value; an all-ones word ends each list
@000
3C011234 34215678 24020005 00221821 // lui, ori, addiu, addu on forwarded operands
00622023 00622824 00A13025 0043382A // subu, and, or, slt true
2408FFFF 0048482A AC030080 8C0A0080 // addiu -1, slt false, sw then lw at 0x80
254B0001 8C0C0040 8C0D0044 018D7021 // load-use consumers
10450002 240F0011 24100022 14450003 // beq taken, slot, skipped, bne not taken
24110033 24120044 14220002 24130055 // slot, fall-through, bne taken, slot
24140066 10220003 24150077 24000099 // skipped, beq not taken, slot, write to r0
0BF0001F 241600AB 24170BAD 0016C021 // j, slot reading r0, skipped, jump target
AC180084 8C1A0084 0BF00022 00000021 // sw, lw back, spin loop and its slot
@110
CAFE0001 000000A5                   // words at 0x40 and 0x44
@200
00000080 1234567D
00000084 000000AB
FFFFFFFF
@280
BFC00000 00000001 12340000
BFC00004 00000001 12345678
BFC00008 00000002 00000005
BFC0000C 00000003 1234567D
BFC00010 00000004 12345678
BFC00014 00000005 00000005
BFC00018 00000006 1234567D
BFC0001C 00000007 00000001
BFC00020 00000008 FFFFFFFF
BFC00024 00000009 00000000
BFC0002C 0000000A 1234567D
BFC00030 0000000B 1234567E
BFC00034 0000000C CAFE0001
BFC00038 0000000D 000000A5
BFC0003C 0000000E CAFE00A6
BFC00044 0000000F 00000011
BFC00050 00000011 00000033
BFC00054 00000012 00000044
BFC0005C 00000013 00000055
BFC00068 00000015 00000077
BFC00074 00000016 000000AB
BFC0007C 00000018 000000AB
BFC00084 0000001A 000000AB
FFFFFFFF

// File: sim.f
+incdir+rtl
rtl/cpu_isa_pkg.sv
rtl/cpu_pipe_pkg.sv
rtl/cpu_regfile.sv
rtl/cpu_fetch.sv
rtl/cpu_decode.sv
rtl/cpu_hazard.sv
rtl/cpu_execute.sv
rtl/cpu_memwb.sv
rtl/mycpu_top.sv
tests/tb_mycpu.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, then judge the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_mycpu \
    -f sim.f --Mdir obj_dir -o tb_mycpu_sim || { echo "build failed"; exit 1; }
./obj_dir/tb_mycpu_sim > sim.log 2>&1 ; cat sim.log
grep -q "Done: errors found" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Done: no errors" sim.log || { echo "simulation did not finish"; exit 1; }
echo "simulation passed"
